//--- all.f
+incdir+.
ooo_pkg.sv
mem_pkg.sv
lsq_circular_queue.sv
lsq_wakeup.sv
lsq_load_align.sv
load_store_queue.sv
phys_regfile.sv
lsq_top.sv
lsq_tb.sv

//--- Bender.yml
package:
  name: lsq

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ooo_pkg.sv
      - mem_pkg.sv
      - lsq_circular_queue.sv
      - lsq_wakeup.sv
      - lsq_load_align.sv
      - load_store_queue.sv
      - phys_regfile.sv
      - lsq_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - lsq_tb.sv

//--- lsq_tb.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_tb;

    import ooo_pkg::*;
    import mem_pkg::*;

    // Ops dispatched over all tests
    localparam int TOTAL_OPS = 48;

    logic clk, rst, flush, stall;
    logic disp_valid, disp_is_store, disp_rs1_ready, disp_rs2_ready, disp_ready;
    logic [2:0] disp_funct3;
    logic [11:0] disp_imm;
    rob_idx_t disp_rob;
    preg_t disp_rs1, disp_rs2, disp_rd, cdb_in_tag, cdb_out_rd;
    logic cdb_in_valid, cdb_out_valid, cdb_out_is_store;
    logic [`XLEN-1:0] cdb_in_data, cdb_out_data;
    rob_idx_t cdb_out_rob;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0] wstrb;
    axi_resp_t bresp, rresp;

    logic [31:0] mem [256];
    logic [31:0] model_mem [256];
    logic [31:0] reg_model [`NUM_PREGS];

    // Program-order record of every dispatched op
    logic op_store [64];
    logic [31:0] op_addr [64];
    logic [31:0] op_wdata [64];
    logic [3:0] op_wstrb [64];
    logic [31:0] op_result [64];
    rob_idx_t op_rob [64];
    preg_t op_rd [64];
    int n_ops, bus_idx, cdb_idx, widx, errors, tests, failed_tests;
    logic st_open, aw_done, ok;

    lsq_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (16 + 400 * TOTAL_OPS) @(posedge clk);
        $display("Timeout: the DUT stopped making progress");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] fill_word(int i);
        return (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f ^ {24'h0, 8'(i)};
    endfunction

    function automatic logic [3:0] byte_mask(logic [2:0] f3);
        return 4'((1 << (1 << f3[1:0])) - 1);
    endfunction

    function automatic logic [31:0] load_expect(logic [31:0] word, logic [1:0] off,
                                                logic [2:0] f3);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (f3)
            3'd0: return 32'($signed(sh[7:0]));
            3'd1: return 32'($signed(sh[15:0]));
            3'd4: return {24'h0, sh[7:0]};
            3'd5: return {16'h0, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_cond(logic cond, string msg);
        assert (cond) else begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic pause(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Read side of the memory
    initial begin
        logic [7:0] ra;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = AXI_OKAY;
        forever begin
            @(posedge clk);
            #1;
            if (arvalid && !stall) begin
                pause($urandom_range(0, 5));
                arready = 1'b1;
                ra = araddr[9:2];
                pause(1);
                arready = 1'b0;
                pause($urandom_range(0, 5));
                rvalid = 1'b1;
                rdata = mem[ra];
                @(negedge clk);
                while (!rready) @(negedge clk);
                pause(1);
                rvalid = 1'b0;
            end
        end
    end

    // Write side accepts AW before W
    initial begin
        logic [7:0] wa;
        logic [31:0] wd;
        logic [3:0] ws;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = AXI_OKAY;
        forever begin
            @(posedge clk);
            #1;
            if (awvalid && !stall) begin
                pause($urandom_range(0, 5));
                awready = 1'b1;
                wa = awaddr[9:2];
                pause(1);
                awready = 1'b0;
                pause($urandom_range(0, 5));
                wready = 1'b1;
                wd = wdata;
                ws = wstrb;
                pause(1);
                wready = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    if (ws[b]) mem[wa][8*b +: 8] = wd[8*b +: 8];
                end
                pause($urandom_range(0, 5));
                bvalid = 1'b1;
                @(negedge clk);
                while (!bready) @(negedge clk);
                pause(1);
                bvalid = 1'b0;
            end
        end
    end

    // Bus and CDB checks at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            bus_idx = 0;
            cdb_idx = 0;
            st_open = 1'b0;
            aw_done = 1'b0;
        end else begin
            if (flush) begin
                bus_idx = n_ops;
                cdb_idx = n_ops;
            end
            if (arvalid) check_cond(!st_open, "Read issued while an older store awaits B");
            if (wvalid && wready) begin
                widx = aw_done ? bus_idx - 1 : bus_idx;
                ok = widx < n_ops && op_store[widx];
                check_cond(ok, "Write data accepted with no store in order");
                if (ok) begin
                    check_value("wstrb", 32'(wstrb), 32'(op_wstrb[widx]));
                    check_value("wdata", wdata, op_wdata[widx]);
                end
            end
            if (awvalid && awready) begin
                ok = bus_idx < n_ops && op_store[bus_idx];
                check_cond(ok, "Write address issued out of program order");
                if (ok) check_value("awaddr", awaddr, op_addr[bus_idx]);
                bus_idx++;
                st_open = 1'b1;
                aw_done = 1'b1;
            end
            if (arvalid && arready) begin
                ok = bus_idx < n_ops && !op_store[bus_idx];
                check_cond(ok, "Read address issued out of program order");
                if (ok) check_value("araddr", araddr, op_addr[bus_idx]);
                bus_idx++;
            end
            if (bvalid && bready) begin
                st_open = 1'b0;
                aw_done = 1'b0;
            end
            if (cdb_out_valid) begin
                ok = cdb_idx < n_ops;
                check_cond(ok, "CDB broadcast with no operation left to complete");
                if (ok) begin
                    check_value("cdb_out_rob", 32'(cdb_out_rob), 32'(op_rob[cdb_idx]));
                    check_value("cdb_out_is_store", 32'(cdb_out_is_store),
                                32'(op_store[cdb_idx]));
                    check_value("cdb_out_data", cdb_out_data, op_result[cdb_idx]);
                    if (!op_store[cdb_idx]) begin
                        check_value("cdb_out_rd", 32'(cdb_out_rd), 32'(op_rd[cdb_idx]));
                    end
                end
                cdb_idx++;
            end
        end
    end

    task automatic set_reg(preg_t tag, logic [31:0] val);
        cdb_in_valid = 1'b1;
        cdb_in_tag = tag;
        cdb_in_data = val;
        reg_model[tag] = val;
        pause(1);
        cdb_in_valid = 1'b0;
    endtask

    // Base is the rs1 value the op will see when it issues
    task automatic dispatch(logic st, logic [2:0] f3, logic [11:0] imm, preg_t rs1,
                            logic rs1_rdy, logic [31:0] base, preg_t rs2, preg_t rd);
        logic [31:0] addr;
        logic [3:0] strb;
        logic [31:0] data;
        addr = base + {{20{imm[11]}}, imm};
        op_store[n_ops] = st;
        op_addr[n_ops] = addr;
        op_rob[n_ops] = rob_idx_t'(n_ops);
        op_rd[n_ops] = rd;
        if (st) begin
            strb = byte_mask(f3) << addr[1:0];
            data = reg_model[rs2] << (8 * addr[1:0]);
            op_wstrb[n_ops] = strb;
            op_wdata[n_ops] = data;
            op_result[n_ops] = '0;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) model_mem[addr[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end else begin
            op_result[n_ops] = load_expect(model_mem[addr[9:2]], addr[1:0], f3);
        end
        disp_valid = 1'b1;
        disp_is_store = st;
        disp_funct3 = f3;
        disp_imm = imm;
        disp_rob = rob_idx_t'(n_ops);
        disp_rs1 = rs1;
        disp_rs1_ready = rs1_rdy;
        disp_rs2 = st ? rs2 : '0;
        disp_rs2_ready = 1'b1;
        disp_rd = rd;
        @(negedge clk);
        while (!disp_ready) @(negedge clk);
        pause(1);
        disp_valid = 1'b0;
        n_ops++;
    endtask

    task automatic drain();
        while (cdb_idx != n_ops) @(posedge clk);
        #1;
    endtask

    task automatic finish_test(string name, int err_before);
        tests++;
        if (errors == err_before) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed", tests, name);
        end
    endtask

    initial begin
        logic [2:0] ld_f3 [5];
        logic [1:0] ld_off [5];
        logic [2:0] f3;
        logic [1:0] off;
        int e0, seed;
        seed = $urandom(32'h55f);
        ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        ld_off = '{2'd3, 2'd2, 2'd0, 2'd1, 2'd0};
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        disp_valid = 1'b0;
        disp_is_store = 1'b0;
        disp_funct3 = '0;
        disp_imm = '0;
        disp_rob = '0;
        disp_rs1 = '0;
        disp_rs1_ready = 1'b0;
        disp_rs2 = '0;
        disp_rs2_ready = 1'b0;
        disp_rd = '0;
        cdb_in_valid = 1'b0;
        cdb_in_tag = '0;
        cdb_in_data = '0;
        n_ops = 0;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < `NUM_PREGS; i++) reg_model[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        set_reg(6'd1, 32'h0000_0100);
        set_reg(6'd2, 32'h80f0_a5c3);
        set_reg(6'd3, 32'hfedc_ba98);

        e0 = errors;
        for (int k = 0; k < 5; k++) begin
            dispatch(1'b1, ld_f3[k] & 3'b011, 12'(16 * k + ld_off[k]), 6'd1, 1'b1,
                     reg_model[1], (k % 2) ? 6'd3 : 6'd2, '0);
            dispatch(1'b0, ld_f3[k], 12'(16 * k + ld_off[k]), 6'd1, 1'b1,
                     reg_model[1], '0, 6'(40 + k));
        end
        drain();
        finish_test("store then load per size", e0);

        e0 = errors;
        for (int k = 0; k < 12; k++) begin
            f3 = 3'($urandom_range(0, 2));
            off = (f3 == 3'd0) ? 2'($urandom_range(0, 3)) : (f3 == 3'd1) ? 2'd2 : 2'd0;
            if (f3 != 3'd2 && $urandom_range(0, 1)) f3[2] = 1'b1;
            if ($urandom_range(0, 1)) begin
                dispatch(1'b1, f3 & 3'b011, 12'(4 * $urandom_range(0, 7) + off), 6'd1, 1'b1,
                         reg_model[1], $urandom_range(0, 1) ? 6'd3 : 6'd2, '0);
            end else begin
                dispatch(1'b0, f3, 12'(4 * $urandom_range(0, 7) + off), 6'd1, 1'b1,
                         reg_model[1], '0, 6'(50 + k));
            end
        end
        drain();
        finish_test("program order", e0);

        e0 = errors;
        dispatch(1'b0, 3'd2, 12'h004, 6'd10, 1'b0, 32'h0000_0200, '0, 6'd33);
        dispatch(1'b1, 3'd2, 12'h040, 6'd1, 1'b1, reg_model[1], 6'd2, '0);
        repeat (20) begin
            @(negedge clk);
            check_cond(!arvalid && !awvalid, "Access issued before rs1 was broadcast");
        end
        pause(1);
        set_reg(6'd10, 32'h0000_0200);
        drain();
        finish_test("operand wakeup", e0);

        e0 = errors;
        for (int b = 0; b < 4; b++) begin
            dispatch(1'b1, 3'd0, 12'(12'h080 + b), 6'd1, 1'b1, reg_model[1], 6'd3, '0);
        end
        dispatch(1'b1, 3'd1, 12'h084, 6'd1, 1'b1, reg_model[1], 6'd2, '0);
        dispatch(1'b1, 3'd1, 12'h086, 6'd1, 1'b1, reg_model[1], 6'd3, '0);
        dispatch(1'b1, 3'd2, 12'h088, 6'd1, 1'b1, reg_model[1], 6'd2, '0);
        drain();
        finish_test("strobe and data alignment", e0);

        e0 = errors;
        stall = 1'b1;
        for (int k = 0; k < 8; k++) begin
            dispatch(1'b0, 3'd2, 12'(4 * k), 6'd1, 1'b1, reg_model[1], '0, 6'(20 + k));
        end
        @(negedge clk);
        check_cond(!disp_ready, "disp_ready still high with a full load queue");
        pause(1);
        stall = 1'b0;
        drain();
        finish_test("back-pressure", e0);

        e0 = errors;
        // Fill the load queue so that only the flush can raise disp_ready again
        for (int k = 0; k < 8; k++) begin
            dispatch(1'b0, 3'd2, 12'(4 * k), 6'd12, 1'b0, 32'h0, '0, 6'(56 + k));
        end
        flush = 1'b1;
        pause(1);
        flush = 1'b0;
        @(negedge clk);
        check_cond(disp_ready, "disp_ready low after flush");
        pause(1);
        set_reg(6'd12, 32'h0000_0300);
        repeat (20) begin
            @(negedge clk);
            check_cond(!arvalid && !awvalid && !cdb_out_valid,
                       "Flushed entry reached the bus or the CDB");
        end
        pause(1);
        dispatch(1'b0, 3'd4, 12'h003, 6'd1, 1'b1, reg_model[1], '0, 6'd34);
        drain();
        finish_test("flush", e0);

        $display("Tests run %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- lsq_top.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_top (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic disp_valid,
    input  logic disp_is_store,
    input  logic [2:0] disp_funct3,
    input  logic [11:0] disp_imm,
    input  ooo_pkg::rob_idx_t disp_rob,
    input  ooo_pkg::preg_t disp_rs1,
    input  logic disp_rs1_ready,
    input  ooo_pkg::preg_t disp_rs2,
    input  logic disp_rs2_ready,
    input  ooo_pkg::preg_t disp_rd,
    output logic disp_ready,
    input  logic cdb_in_valid,
    input  ooo_pkg::preg_t cdb_in_tag,
    input  logic [`XLEN-1:0] cdb_in_data,
    output logic awvalid,
    input  logic awready,
    output logic [31:0] awaddr,
    output logic wvalid,
    input  logic wready,
    output logic [31:0] wdata,
    output logic [3:0] wstrb,
    input  logic bvalid,
    output logic bready,
    input  mem_pkg::axi_resp_t bresp,
    output logic arvalid,
    input  logic arready,
    output logic [31:0] araddr,
    input  logic rvalid,
    output logic rready,
    input  logic [31:0] rdata,
    input  mem_pkg::axi_resp_t rresp,
    output logic cdb_out_valid,
    output ooo_pkg::rob_idx_t cdb_out_rob,
    output ooo_pkg::preg_t cdb_out_rd,
    output logic [`XLEN-1:0] cdb_out_data,
    output logic cdb_out_is_store
);

    ooo_pkg::preg_t rd_tag1;
    ooo_pkg::preg_t rd_tag2;
    logic [`XLEN-1:0] rd_data1;
    logic [`XLEN-1:0] rd_data2;

    load_store_queue lsq (.*);

    // Operands come from the CDB input only
    phys_regfile prf (
        .clk(clk),
        .rst(rst),
        .wr_en(cdb_in_valid),
        .wr_tag(cdb_in_tag),
        .wr_data(cdb_in_data),
        .rd_tag1(rd_tag1),
        .rd_tag2(rd_tag2),
        .rd_data1(rd_data1),
        .rd_data2(rd_data2)
    );

endmodule

//--- phys_regfile.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module phys_regfile (
    input  logic clk,
    input  logic rst,
    input  logic wr_en,
    input  ooo_pkg::preg_t wr_tag,
    input  logic [`XLEN-1:0] wr_data,
    input  ooo_pkg::preg_t rd_tag1,
    input  ooo_pkg::preg_t rd_tag2,
    output logic [`XLEN-1:0] rd_data1,
    output logic [`XLEN-1:0] rd_data2
);

    logic [`XLEN-1:0] regs [`NUM_PREGS];

    // Register 0 is never written and stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_tag != '0) begin
            regs[wr_tag] <= wr_data;
        end
    end

    assign rd_data1 = regs[rd_tag1];
    assign rd_data2 = regs[rd_tag2];

endmodule

//--- load_store_queue.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module load_store_queue (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic disp_valid,
    input  logic disp_is_store,
    input  logic [2:0] disp_funct3,
    input  logic [11:0] disp_imm,
    input  ooo_pkg::rob_idx_t disp_rob,
    input  ooo_pkg::preg_t disp_rs1,
    input  logic disp_rs1_ready,
    input  ooo_pkg::preg_t disp_rs2,
    input  logic disp_rs2_ready,
    input  ooo_pkg::preg_t disp_rd,
    output logic disp_ready,
    input  logic cdb_in_valid,
    input  ooo_pkg::preg_t cdb_in_tag,
    output ooo_pkg::preg_t rd_tag1,
    output ooo_pkg::preg_t rd_tag2,
    input  logic [`XLEN-1:0] rd_data1,
    input  logic [`XLEN-1:0] rd_data2,
    output logic awvalid,
    input  logic awready,
    output logic [31:0] awaddr,
    output logic wvalid,
    input  logic wready,
    output logic [31:0] wdata,
    output logic [3:0] wstrb,
    input  logic bvalid,
    output logic bready,
    input  mem_pkg::axi_resp_t bresp,
    output logic arvalid,
    input  logic arready,
    output logic [31:0] araddr,
    input  logic rvalid,
    output logic rready,
    input  logic [31:0] rdata,
    input  mem_pkg::axi_resp_t rresp,
    output logic cdb_out_valid,
    output ooo_pkg::rob_idx_t cdb_out_rob,
    output ooo_pkg::preg_t cdb_out_rd,
    output logic [`XLEN-1:0] cdb_out_data,
    output logic cdb_out_is_store
);

    import ooo_pkg::*;
    import mem_pkg::*;

    lsq_entry_t ld_entries [`LSQ_DEPTH];
    lsq_entry_t st_entries [`LSQ_DEPTH];
    lsq_entry_t ld_upd [`LSQ_DEPTH];
    lsq_entry_t st_upd [`LSQ_DEPTH];
    logic [`LSQ_DEPTH-1:0] ld_upd_mask;
    logic [`LSQ_DEPTH-1:0] st_upd_mask;
    lsq_ptr_t ld_head, ld_tail, st_head, st_tail;
    logic ld_full, st_full;
    logic push_ld, push_st, pop_ld, pop_st;
    lsq_entry_t disp_entry;
    lsq_entry_t ld_top, st_top, issue_entry;
    logic ld_ok, st_ok, start, start_ld, start_st;

    lsq_state_t state;
    logic killed;
    logic aw_pend, w_pend;
    logic is_store_q;
    logic [2:0] funct3_q;
    rob_idx_t rob_q;
    preg_t rd_q;
    logic [`XLEN-1:0] addr_q, sdata_q, data_q, ld_aligned, base_addr;
    logic [3:0] size_mask;

    // With a full partner queue its head equals its tail and the cross pointer is ambiguous
    assign disp_ready = !ld_full && !st_full;
    assign push_ld = disp_valid && disp_ready && !disp_is_store && !flush;
    assign push_st = disp_valid && disp_ready && disp_is_store && !flush;

    always_comb begin
        disp_entry.valid = 1'b1;
        disp_entry.rob = disp_rob;
        disp_entry.funct3 = disp_funct3;
        disp_entry.rs1 = disp_rs1;
        // Also catch a broadcast in the dispatch cycle itself
        disp_entry.rs1_ready = disp_rs1_ready || (cdb_in_valid && cdb_in_tag == disp_rs1);
        disp_entry.rs2 = disp_rs2;
        disp_entry.rs2_ready = !disp_is_store || disp_rs2_ready
                               || (cdb_in_valid && cdb_in_tag == disp_rs2);
        disp_entry.rd = disp_is_store ? '0 : disp_rd;
        disp_entry.imm = disp_imm;
        disp_entry.cross_ptr = disp_is_store ? ld_tail : st_tail;
        disp_entry.cross_met = 1'b0;
    end

    lsq_circular_queue load_q (
        .clk(clk),
        .rst(rst || flush),
        .push(push_ld),
        .pop(pop_ld),
        .push_entry(disp_entry),
        .upd_entries(ld_upd),
        .upd_mask(ld_upd_mask),
        .entries(ld_entries),
        .head(ld_head),
        .tail(ld_tail),
        .full(ld_full)
    );

    lsq_circular_queue store_q (
        .clk(clk),
        .rst(rst || flush),
        .push(push_st),
        .pop(pop_st),
        .push_entry(disp_entry),
        .upd_entries(st_upd),
        .upd_mask(st_upd_mask),
        .entries(st_entries),
        .head(st_head),
        .tail(st_tail),
        .full(st_full)
    );

    lsq_wakeup load_wakeup (
        .entries(ld_entries),
        .cdb_in_valid(cdb_in_valid),
        .cdb_in_tag(cdb_in_tag),
        .other_head(st_head),
        .issue(start_ld),
        .issue_ptr(ld_head),
        .upd_entries(ld_upd),
        .upd_mask(ld_upd_mask)
    );

    lsq_wakeup store_wakeup (
        .entries(st_entries),
        .cdb_in_valid(cdb_in_valid),
        .cdb_in_tag(cdb_in_tag),
        .other_head(ld_head),
        .issue(start_st),
        .issue_ptr(st_head),
        .upd_entries(st_upd),
        .upd_mask(st_upd_mask)
    );

    // Cross pointers leave at most one head eligible
    assign ld_top = ld_entries[ld_head];
    assign st_top = st_entries[st_head];
    assign ld_ok = ld_top.valid && ld_top.rs1_ready && ld_top.rs2_ready && ld_top.cross_met;
    assign st_ok = st_top.valid && st_top.rs1_ready && st_top.rs2_ready && st_top.cross_met;
    assign start = (state == IDLE) && (ld_ok || st_ok) && !flush;
    assign start_ld = start && ld_ok;
    assign start_st = start && !ld_ok;

    assign issue_entry = ld_ok ? ld_top : st_top;
    assign rd_tag1 = issue_entry.rs1;
    assign rd_tag2 = issue_entry.rs2;
    assign base_addr = rd_data1 + {{(`XLEN-12){issue_entry.imm[11]}}, issue_entry.imm};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            killed <= 1'b0;
            aw_pend <= 1'b0;
            w_pend <= 1'b0;
        end else begin
            if (state == DONE) begin
                killed <= 1'b0;
            end else if (flush && state != IDLE) begin
                killed <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start_ld) begin
                        state <= ISSUE_LD;
                    end else if (start_st) begin
                        state <= ISSUE_ST;
                        aw_pend <= 1'b1;
                        w_pend <= 1'b1;
                    end
                end
                ISSUE_LD: if (arready) state <= WAIT_R;
                ISSUE_ST: begin
                    if (awready) aw_pend <= 1'b0;
                    if (wready) w_pend <= 1'b0;
                    if ((!aw_pend || awready) && (!w_pend || wready)) begin
                        state <= WAIT_B;
                    end
                end
                WAIT_R: if (rvalid) state <= DONE;
                WAIT_B: if (bvalid) state <= DONE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_store_q <= !ld_ok;
            funct3_q <= issue_entry.funct3;
            rob_q <= issue_entry.rob;
            rd_q <= issue_entry.rd;
            addr_q <= base_addr;
            sdata_q <= rd_data2;
        end
        // Loads return data, stores return their response code
        if (state == WAIT_R && rvalid) begin
            data_q <= (rresp == AXI_OKAY) ? ld_aligned : '0;
        end
        if (state == WAIT_B && bvalid) begin
            data_q <= {{(`XLEN-2){1'b0}}, bresp};
        end
    end

    lsq_load_align align (
        .rdata(rdata),
        .offset(addr_q[1:0]),
        .funct3(funct3_q),
        .result(ld_aligned)
    );

    always_comb begin
        case (mem_size_t'(funct3_q[1:0]))
            SIZE_B: size_mask = 4'b0001;
            SIZE_H: size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    assign arvalid = (state == ISSUE_LD);
    assign araddr = addr_q;
    assign awvalid = (state == ISSUE_ST) && aw_pend;
    assign awaddr = addr_q;
    assign wvalid = (state == ISSUE_ST) && w_pend;
    assign wstrb = size_mask << addr_q[1:0];
    assign wdata = sdata_q << {addr_q[1:0], 3'b000};
    assign rready = (state == WAIT_R);
    assign bready = (state == WAIT_B);

    // A flushed access finishes on the bus but neither pops nor broadcasts
    assign pop_ld = (state == DONE) && !is_store_q && !killed;
    assign pop_st = (state == DONE) && is_store_q && !killed;
    assign cdb_out_valid = (state == DONE) && !killed && !flush;
    assign cdb_out_rob = rob_q;
    assign cdb_out_rd = rd_q;
    assign cdb_out_data = data_q;
    assign cdb_out_is_store = is_store_q;

endmodule

//--- lsq_load_align.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_load_align (
    input  logic [`XLEN-1:0] rdata,
    input  logic [1:0] offset,
    input  logic [2:0] funct3,
    output logic [`XLEN-1:0] result
);

    import mem_pkg::*;

    logic [`XLEN-1:0] lane;
    mem_size_t size;

    // Addressed byte lane moved down to bit 0
    assign lane = rdata >> {offset, 3'b000};
    assign size = mem_size_t'(funct3[1:0]);

    always_comb begin
        case (size)
            SIZE_B: begin
                if (funct3[2]) begin
                    result = {{(`XLEN-8){1'b0}}, lane[7:0]};
                end else begin
                    result = {{(`XLEN-8){lane[7]}}, lane[7:0]};
                end
            end
            SIZE_H: begin
                if (funct3[2]) begin
                    result = {{(`XLEN-16){1'b0}}, lane[15:0]};
                end else begin
                    result = {{(`XLEN-16){lane[15]}}, lane[15:0]};
                end
            end
            default: result = lane;
        endcase
    end

endmodule

//--- lsq_wakeup.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_wakeup (
    input  ooo_pkg::lsq_entry_t entries [`LSQ_DEPTH],
    input  logic cdb_in_valid,
    input  ooo_pkg::preg_t cdb_in_tag,
    input  ooo_pkg::lsq_ptr_t other_head,
    input  logic issue,
    input  ooo_pkg::lsq_ptr_t issue_ptr,
    output ooo_pkg::lsq_entry_t upd_entries [`LSQ_DEPTH],
    output logic [`LSQ_DEPTH-1:0] upd_mask
);

    import ooo_pkg::*;

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            upd_entries[i] = entries[i];
            upd_mask[i] = 1'b0;
            if (entries[i].valid) begin
                if (cdb_in_valid && !entries[i].rs1_ready && entries[i].rs1 == cdb_in_tag) begin
                    upd_entries[i].rs1_ready = 1'b1;
                    upd_mask[i] = 1'b1;
                end
                if (cdb_in_valid && !entries[i].rs2_ready && entries[i].rs2 == cdb_in_tag) begin
                    upd_entries[i].rs2_ready = 1'b1;
                    upd_mask[i] = 1'b1;
                end
                // Every older access of the other queue has popped
                if (!entries[i].cross_met && entries[i].cross_ptr == other_head) begin
                    upd_entries[i].cross_met = 1'b1;
                    upd_mask[i] = 1'b1;
                end
                if (issue && issue_ptr == lsq_ptr_t'(i)) begin
                    upd_entries[i].valid = 1'b0;
                    upd_mask[i] = 1'b1;
                end
            end
        end
    end

endmodule

//--- lsq_circular_queue.sv
`timescale 1ns/1ps
`include "lsq_consts.svh"

module lsq_circular_queue (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  ooo_pkg::lsq_entry_t push_entry,
    input  ooo_pkg::lsq_entry_t upd_entries [`LSQ_DEPTH],
    input  logic [`LSQ_DEPTH-1:0] upd_mask,
    output ooo_pkg::lsq_entry_t entries [`LSQ_DEPTH],
    output ooo_pkg::lsq_ptr_t head,
    output ooo_pkg::lsq_ptr_t tail,
    output logic full
);

    import ooo_pkg::*;

    lsq_entry_t ring [`LSQ_DEPTH];
    // Extra top bit tells full from empty
    logic [`LSQ_PTR_W:0] head_q;
    logic [`LSQ_PTR_W:0] tail_q;

    assign head = head_q[`LSQ_PTR_W-1:0];
    assign tail = tail_q[`LSQ_PTR_W-1:0];
    assign full = (head_q[`LSQ_PTR_W] != tail_q[`LSQ_PTR_W]) && (head == tail);
    assign entries = ring;

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (push && !full) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // Push takes priority over an update of the same slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (rst) begin
                ring[i].valid <= 1'b0;
            end else if (push && !full && tail == lsq_ptr_t'(i)) begin
                ring[i] <= push_entry;
            end else if (upd_mask[i]) begin
                ring[i] <= upd_entries[i];
            end
        end
    end

endmodule

//--- mem_pkg.sv
package mem_pkg;

    // Access width as coded in funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } mem_size_t;

    typedef enum logic [2:0] {
        IDLE,
        ISSUE_LD,
        ISSUE_ST,
        WAIT_R,
        WAIT_B,
        DONE
    } lsq_state_t;

    typedef enum logic [1:0] {
        AXI_OKAY = 2'b00,
        AXI_SLVERR = 2'b10
    } axi_resp_t;

endpackage

//--- ooo_pkg.sv
`include "lsq_consts.svh"

package ooo_pkg;

    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`ROB_W-1:0] rob_idx_t;
    typedef logic [`LSQ_PTR_W-1:0] lsq_ptr_t;

    // One load or store waiting in its queue
    typedef struct packed {
        logic valid;
        rob_idx_t rob;
        logic [2:0] funct3;
        preg_t rs1;
        logic rs1_ready;
        preg_t rs2;
        logic rs2_ready;
        preg_t rd;
        logic [11:0] imm;
        // Tail of the other queue when this entry was dispatched
        lsq_ptr_t cross_ptr;
        logic cross_met;
    } lsq_entry_t;

endpackage

//--- lsq_consts.svh
`ifndef LSQ_CONSTS_SVH
`define LSQ_CONSTS_SVH

// Queue geometry
`define LSQ_DEPTH 8
`define LSQ_PTR_W 3

// Rename and datapath widths
`define NUM_PREGS 64
`define PREG_W 6
`define ROB_W 5
`define XLEN 32

`endif
